//--- Bender.yml
package:
  name: dsp_engine

sources:
  - files:
      - hw/dsp_pkg.sv
      - hw/dsp_alu.sv
      - hw/block_store.sv
      - hw/dsp_core.sv
      - hw/dsp_top.sv
  - target: test
    files:
      - tests/dsp_top_chk.sv
      - tests/dsp_top_tb.sv

//--- hw/block_store.sv
module block_store (
	input logic clk,
	input logic reset,
	input logic command_instr_write,
	input logic [dsp_pkg::block_addr_width-1:0] command_block_target,
	input logic [dsp_pkg::instr_width-1:0] command_instr_write_val,
	input logic [dsp_pkg::block_addr_width-1:0] current_block,
	input logic reg_write,
	input logic [dsp_pkg::global_addr_width-1:0] reg_write_addr,
	input logic signed [dsp_pkg::data_width-1:0] reg_write_val,
	input logic [dsp_pkg::global_addr_width-1:0] reg_fetch_addr,
	input logic ch_write,
	input logic [dsp_pkg::reg_addr_width-1:0] ch_write_addr,
	input logic signed [dsp_pkg::data_width-1:0] ch_write_val,
	input logic [dsp_pkg::reg_addr_width-1:0] ch_fetch_addr,
	input logic sample_load,
	input logic signed [dsp_pkg::data_width-1:0] sample_in,
	output logic [dsp_pkg::instr_width-1:0] instr,
	output logic signed [dsp_pkg::data_width-1:0] reg_fetch,
	output logic signed [dsp_pkg::data_width-1:0] ch_fetch,
	output logic [dsp_pkg::block_addr_width-1:0] last_block
);

	logic [dsp_pkg::instr_width-1:0] instr_mem [dsp_pkg::n_blocks];
	logic signed [dsp_pkg::data_width-1:0] regs [dsp_pkg::n_blocks * dsp_pkg::n_registers];
	logic signed [dsp_pkg::data_width-1:0] ch_regs [dsp_pkg::n_channels];

	// Instruction memory
	always_ff @(posedge clk) begin
		instr <= instr_mem[current_block];
		if (command_instr_write) begin
			instr_mem[command_block_target] <= command_instr_write_val;
		end
	end

	// Chain length follows the highest block ever written
	always_ff @(posedge clk) begin
		if (reset) begin
			last_block <= '0;
		end else if (command_instr_write && command_block_target > last_block) begin
			last_block <= command_block_target;
		end
	end

	// Block registers, addressed by block and register index
	always_ff @(posedge clk) begin
		reg_fetch <= regs[reg_fetch_addr];
		if (reg_write) begin
			regs[reg_write_addr] <= reg_write_val;
		end
	end

	always_ff @(posedge clk) begin
		ch_fetch <= ch_regs[ch_fetch_addr];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < dsp_pkg::n_channels; i++) begin
				ch_regs[i] <= '0;
			end
		end else begin
			if (ch_write) begin
				ch_regs[ch_write_addr] <= ch_write_val;
			end
			// New sample enters on channel 0
			if (sample_load) begin
				ch_regs[0] <= sample_in;
			end
		end
	end

endmodule

//--- hw/dsp_alu.sv
module dsp_alu (
	input dsp_pkg::alu_op_t alu_op,
	input logic signed [dsp_pkg::data_width-1:0] opnd_a,
	input logic signed [dsp_pkg::data_width-1:0] opnd_b,
	input logic signed [dsp_pkg::data_width-1:0] opnd_c,
	input logic saturate,
	input logic [dsp_pkg::shift_width-1:0] shift,
	output logic signed [dsp_pkg::data_width-1:0] alu_result,
	output logic signed [dsp_pkg::data_width-1:0] clamp_max,
	output logic signed [dsp_pkg::data_width-1:0] clamp_min
);

	// Narrow a one-bit-wide sum back to sample width
	function automatic logic signed [dsp_pkg::data_width-1:0] narrow(
		input logic signed [dsp_pkg::data_width:0] value,
		input logic sat
	);
		logic signed [dsp_pkg::data_width-1:0] result;
		if (sat && value > dsp_pkg::sat_max) begin
			result = dsp_pkg::sat_max;
		end else if (sat && value < dsp_pkg::sat_min) begin
			result = dsp_pkg::sat_min;
		end else begin
			result = value[dsp_pkg::data_width-1:0];
		end
		return result;
	endfunction

	logic signed [dsp_pkg::data_width:0] a_ext;
	logic signed [dsp_pkg::data_width:0] b_ext;
	logic signed [dsp_pkg::data_width:0] c_ext;
	logic signed [dsp_pkg::data_width:0] addsub_sum;
	logic signed [dsp_pkg::data_width:0] mac_sum;
	logic signed [dsp_pkg::data_width:0] mul_ext;

	logic signed [2*dsp_pkg::data_width-1:0] product;
	logic signed [2*dsp_pkg::data_width-1:0] product_shifted;
	logic [3:0] product_rshift;
	logic signed [dsp_pkg::data_width-1:0] mul_value;

	assign a_ext = {opnd_a[dsp_pkg::data_width-1], opnd_a};
	assign b_ext = {opnd_b[dsp_pkg::data_width-1], opnd_b};
	assign c_ext = {opnd_c[dsp_pkg::data_width-1], opnd_c};

	assign addsub_sum = (alu_op == dsp_pkg::alu_sub) ? a_ext - b_ext : a_ext + b_ext;

	// Q1.15 product, the extra shift lowers the right shift
	assign product = opnd_a * opnd_b;
	assign product_rshift = 4'(dsp_pkg::data_width - 1) - 4'(shift);
	assign product_shifted = product >>> product_rshift;

	always_comb begin
		if (saturate && product_shifted > dsp_pkg::sat_max) begin
			mul_value = dsp_pkg::sat_max;
		end else if (saturate && product_shifted < dsp_pkg::sat_min) begin
			mul_value = dsp_pkg::sat_min;
		end else begin
			mul_value = product_shifted[dsp_pkg::data_width-1:0];
		end
	end

	assign mul_ext = {mul_value[dsp_pkg::data_width-1], mul_value};
	assign mac_sum = mul_ext + c_ext;

	always_comb begin
		case (alu_op)
			dsp_pkg::alu_mul: alu_result = mul_value;
			dsp_pkg::alu_mac: alu_result = narrow(mac_sum, saturate);
			default: alu_result = narrow(addsub_sum, saturate);
		endcase
	end

	// Limits for clamp
	assign clamp_max = dsp_pkg::sat_max >>> shift;
	assign clamp_min = dsp_pkg::sat_min >>> shift;

endmodule

//--- hw/dsp_core.sv
module dsp_core (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic command_reg_write,
	input logic [dsp_pkg::block_addr_width-1:0] command_block_target,
	input logic [dsp_pkg::reg_addr_width-1:0] command_reg_target,
	input logic signed [dsp_pkg::data_width-1:0] command_reg_write_val,
	input logic [dsp_pkg::instr_width-1:0] instr,
	input logic signed [dsp_pkg::data_width-1:0] reg_fetch,
	input logic signed [dsp_pkg::data_width-1:0] ch_fetch,
	input logic [dsp_pkg::block_addr_width-1:0] last_block,
	input logic signed [dsp_pkg::data_width-1:0] alu_result,
	input logic signed [dsp_pkg::data_width-1:0] clamp_max,
	input logic signed [dsp_pkg::data_width-1:0] clamp_min,
	output logic signed [dsp_pkg::data_width-1:0] sample_out,
	output logic ready,
	output logic reg_write_ack,
	output logic sample_load,
	output logic [dsp_pkg::block_addr_width-1:0] current_block,
	output logic [dsp_pkg::global_addr_width-1:0] reg_fetch_addr,
	output logic [dsp_pkg::reg_addr_width-1:0] ch_fetch_addr,
	output logic reg_write,
	output logic [dsp_pkg::global_addr_width-1:0] reg_write_addr,
	output logic signed [dsp_pkg::data_width-1:0] reg_write_val,
	output logic ch_write,
	output logic [dsp_pkg::reg_addr_width-1:0] ch_write_addr,
	output logic signed [dsp_pkg::data_width-1:0] ch_write_val,
	output logic signed [dsp_pkg::data_width-1:0] opnd_a,
	output logic signed [dsp_pkg::data_width-1:0] opnd_b,
	output logic signed [dsp_pkg::data_width-1:0] opnd_c,
	output dsp_pkg::alu_op_t alu_op,
	output logic saturate,
	output logic [dsp_pkg::shift_width-1:0] shift
);

	function automatic logic [1:0] operand_count(input dsp_pkg::opcode_t op);
		logic [1:0] count;
		case (op)
			dsp_pkg::op_add, dsp_pkg::op_sub, dsp_pkg::op_mul, dsp_pkg::op_gw: count = 2'd2;
			dsp_pkg::op_mac: count = 2'd3;
			default: count = 2'd1;
		endcase
		return count;
	endfunction

	dsp_pkg::core_state_t state;
	dsp_pkg::opcode_t opcode;

	logic [dsp_pkg::reg_addr_width-1:0] src_a;
	logic [dsp_pkg::reg_addr_width-1:0] src_b;
	logic [dsp_pkg::reg_addr_width-1:0] src_c;
	logic [dsp_pkg::reg_addr_width-1:0] dest;
	logic src_a_reg;
	logic src_b_reg;
	logic src_c_reg;
	logic dest_reg;

	logic [1:0] op_idx;
	logic [dsp_pkg::reg_addr_width-1:0] operand_addr;
	logic operand_is_reg;
	logic signed [dsp_pkg::data_width-1:0] operand_val;
	logic signed [dsp_pkg::data_width-1:0] work;

	logic cmd_write_prev;
	logic write_pending;

	// Instruction fields
	assign opcode = dsp_pkg::opcode_t'(instr[dsp_pkg::op_width-1:0]);
	assign src_a = instr[dsp_pkg::src_a_lsb +: dsp_pkg::reg_addr_width];
	assign src_b = instr[dsp_pkg::src_b_lsb +: dsp_pkg::reg_addr_width];
	assign src_c = instr[dsp_pkg::src_c_lsb +: dsp_pkg::reg_addr_width];
	assign dest = instr[dsp_pkg::dest_lsb +: dsp_pkg::reg_addr_width];
	assign src_a_reg = instr[dsp_pkg::type_lsb];
	assign src_b_reg = instr[dsp_pkg::type_lsb + 1];
	assign src_c_reg = instr[dsp_pkg::type_lsb + 2];
	assign dest_reg = instr[dsp_pkg::type_lsb + 3];
	assign saturate = ~instr[dsp_pkg::nosat_bit];
	assign shift = instr[dsp_pkg::shift_lsb +: dsp_pkg::shift_width];

	always_comb begin
		case (opcode)
			dsp_pkg::op_sub: alu_op = dsp_pkg::alu_sub;
			dsp_pkg::op_mul: alu_op = dsp_pkg::alu_mul;
			dsp_pkg::op_mac: alu_op = dsp_pkg::alu_mac;
			default: alu_op = dsp_pkg::alu_add;
		endcase
	end

	// Operand select, address goes out in st_fetch and data is back in st_fetch_wait
	always_comb begin
		case (op_idx)
			2'd0: begin
				operand_addr = src_a;
				operand_is_reg = src_a_reg;
			end
			2'd1: begin
				operand_addr = src_b;
				operand_is_reg = src_b_reg;
			end
			default: begin
				operand_addr = src_c;
				operand_is_reg = src_c_reg;
			end
		endcase
	end

	assign operand_val = operand_is_reg ? reg_fetch : ch_fetch;
	assign reg_fetch_addr = {current_block, operand_addr};
	// Channel 0 holds the output at the end of the chain
	assign ch_fetch_addr = (state == dsp_pkg::st_finish) ? '0 : operand_addr;

	assign sample_load = (state == dsp_pkg::st_ready) && tick;
	assign reg_write_ack = (state == dsp_pkg::st_ready) && write_pending;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dsp_pkg::st_ready;
			ready <= 1'b1;
			current_block <= '0;
			op_idx <= '0;
			reg_write <= 1'b0;
			ch_write <= 1'b0;
			sample_out <= '0;
			cmd_write_prev <= 1'b0;
			write_pending <= 1'b0;
		end else begin
			reg_write <= 1'b0;
			ch_write <= 1'b0;
			cmd_write_prev <= command_reg_write;

			case (state)
				dsp_pkg::st_ready: begin
					if (write_pending) begin
						reg_write <= 1'b1;
						reg_write_addr <= {command_block_target, command_reg_target};
						reg_write_val <= command_reg_write_val;
						write_pending <= 1'b0;
					end
					if (tick) begin
						current_block <= '0;
						ready <= 1'b0;
						state <= dsp_pkg::st_block_start;
					end
				end

				dsp_pkg::st_block_start: begin
					op_idx <= '0;
					state <= dsp_pkg::st_fetch;
				end

				dsp_pkg::st_fetch: begin
					state <= dsp_pkg::st_fetch_wait;
				end

				dsp_pkg::st_fetch_wait: begin
					case (op_idx)
						2'd0: opnd_a <= operand_val;
						2'd1: opnd_b <= operand_val;
						default: opnd_c <= operand_val;
					endcase
					op_idx <= op_idx + 2'd1;
					// Operand c is always the last one
					if (op_idx == 2'd2) begin
						state <= dsp_pkg::st_exec;
					end else begin
						state <= dsp_pkg::st_dispatch;
					end
				end

				dsp_pkg::st_dispatch: begin
					case (opcode)
						dsp_pkg::op_add, dsp_pkg::op_sub, dsp_pkg::op_mul, dsp_pkg::op_mac,
						dsp_pkg::op_gw, dsp_pkg::op_lsh, dsp_pkg::op_rsh, dsp_pkg::op_arsh,
						dsp_pkg::op_abs, dsp_pkg::op_mov, dsp_pkg::op_clamp: begin
							if (op_idx < operand_count(opcode)) begin
								state <= dsp_pkg::st_fetch;
							end else begin
								state <= dsp_pkg::st_exec;
							end
						end
						// Nop and unused codes write nothing
						default: state <= dsp_pkg::st_continue;
					endcase
				end

				dsp_pkg::st_exec: begin
					case (opcode)
						dsp_pkg::op_add, dsp_pkg::op_sub, dsp_pkg::op_mul, dsp_pkg::op_mac: begin
							work <= alu_result;
						end
						dsp_pkg::op_lsh: work <= {opnd_a[dsp_pkg::data_width-2:0], 1'b0};
						dsp_pkg::op_rsh: work <= {1'b0, opnd_a[dsp_pkg::data_width-1:1]};
						dsp_pkg::op_arsh: work <= opnd_a >>> 1;
						// Most negative value wraps to itself
						dsp_pkg::op_abs: work <= (opnd_a < 0) ? -opnd_a : opnd_a;
						dsp_pkg::op_gw: work <= opnd_b;
						dsp_pkg::op_clamp: begin
							if (opnd_a < clamp_min) begin
								work <= clamp_min;
							end else if (opnd_a > clamp_max) begin
								work <= clamp_max;
							end else begin
								work <= opnd_a;
							end
						end
						default: work <= opnd_a;
					endcase
					state <= dsp_pkg::st_finish_block;
				end

				dsp_pkg::st_finish_block: begin
					if (opcode == dsp_pkg::op_gw) begin
						// Global address comes from operand a
						reg_write <= 1'b1;
						reg_write_addr <= opnd_a[dsp_pkg::global_addr_width-1:0];
						reg_write_val <= work;
					end else if (dest_reg) begin
						reg_write <= 1'b1;
						reg_write_addr <= {current_block, dest};
						reg_write_val <= work;
					end else begin
						ch_write <= 1'b1;
						ch_write_addr <= dest;
						ch_write_val <= work;
					end
					state <= dsp_pkg::st_continue;
				end

				dsp_pkg::st_continue: begin
					if (current_block == last_block) begin
						state <= dsp_pkg::st_finish;
					end else begin
						current_block <= current_block + 1'b1;
						state <= dsp_pkg::st_block_start;
					end
				end

				dsp_pkg::st_finish: begin
					state <= dsp_pkg::st_finish_wait;
				end

				dsp_pkg::st_finish_wait: begin
					sample_out <= ch_fetch;
					ready <= 1'b1;
					state <= dsp_pkg::st_ready;
				end

				default: begin
					ready <= 1'b1;
					state <= dsp_pkg::st_ready;
				end
			endcase

			// Remember a rising host write strobe until it is served
			if (command_reg_write && !cmd_write_prev) begin
				write_pending <= 1'b1;
			end
		end
	end

endmodule

//--- hw/dsp_pkg.sv
package dsp_pkg;

	// Datapath and memory sizes
	localparam int data_width = 16;
	localparam int n_blocks = 16;
	localparam int block_addr_width = 4;
	localparam int n_registers = 16;
	localparam int reg_addr_width = 4;
	localparam int n_channels = 16;
	localparam int global_addr_width = block_addr_width + reg_addr_width;

	// Instruction word layout
	localparam int op_width = 4;
	localparam int shift_width = 3;
	localparam int src_a_lsb = op_width;
	localparam int src_b_lsb = src_a_lsb + reg_addr_width;
	localparam int src_c_lsb = src_b_lsb + reg_addr_width;
	localparam int dest_lsb = src_c_lsb + reg_addr_width;
	// Operand kind bits in order a, b, c, dest; set means block register
	localparam int type_lsb = dest_lsb + reg_addr_width;
	localparam int nosat_bit = type_lsb + 4;
	localparam int shift_lsb = nosat_bit + 1;
	localparam int instr_width = shift_lsb + shift_width;

	// Signed sample limits
	localparam logic signed [data_width-1:0] sat_max = {1'b0, {(data_width - 1){1'b1}}};
	localparam logic signed [data_width-1:0] sat_min = {1'b1, {(data_width - 1){1'b0}}};

	typedef enum logic [op_width-1:0] {
		op_nop   = 4'd0,
		op_add   = 4'd1,
		op_sub   = 4'd2,
		op_lsh   = 4'd3,
		op_rsh   = 4'd4,
		op_arsh  = 4'd5,
		op_mul   = 4'd6,
		op_mac   = 4'd7,
		op_abs   = 4'd8,
		op_gw    = 4'd9,
		op_mov   = 4'd10,
		op_clamp = 4'd11
	} opcode_t;

	// Result select for the arithmetic unit
	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_mul,
		alu_mac
	} alu_op_t;

	typedef enum logic [3:0] {
		st_ready,
		st_block_start,
		st_fetch,
		st_fetch_wait,
		st_dispatch,
		st_exec,
		st_finish_block,
		st_continue,
		st_finish,
		st_finish_wait
	} core_state_t;

endpackage

//--- hw/dsp_top.sv
module dsp_top (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic signed [dsp_pkg::data_width-1:0] sample_in,
	output logic signed [dsp_pkg::data_width-1:0] sample_out,
	output logic ready,
	input logic command_reg_write,
	input logic command_instr_write,
	input logic [dsp_pkg::block_addr_width-1:0] command_block_target,
	input logic [dsp_pkg::reg_addr_width-1:0] command_reg_target,
	input logic [dsp_pkg::instr_width-1:0] command_instr_write_val,
	input logic signed [dsp_pkg::data_width-1:0] command_reg_write_val,
	output logic reg_write_ack
);

	logic sample_load;
	logic [dsp_pkg::block_addr_width-1:0] current_block;
	logic [dsp_pkg::block_addr_width-1:0] last_block;
	logic [dsp_pkg::instr_width-1:0] instr;

	logic [dsp_pkg::global_addr_width-1:0] reg_fetch_addr;
	logic [dsp_pkg::global_addr_width-1:0] reg_write_addr;
	logic signed [dsp_pkg::data_width-1:0] reg_fetch;
	logic signed [dsp_pkg::data_width-1:0] reg_write_val;
	logic reg_write;

	logic [dsp_pkg::reg_addr_width-1:0] ch_fetch_addr;
	logic [dsp_pkg::reg_addr_width-1:0] ch_write_addr;
	logic signed [dsp_pkg::data_width-1:0] ch_fetch;
	logic signed [dsp_pkg::data_width-1:0] ch_write_val;
	logic ch_write;

	logic signed [dsp_pkg::data_width-1:0] opnd_a;
	logic signed [dsp_pkg::data_width-1:0] opnd_b;
	logic signed [dsp_pkg::data_width-1:0] opnd_c;
	logic signed [dsp_pkg::data_width-1:0] alu_result;
	logic signed [dsp_pkg::data_width-1:0] clamp_max;
	logic signed [dsp_pkg::data_width-1:0] clamp_min;
	dsp_pkg::alu_op_t alu_op;
	logic saturate;
	logic [dsp_pkg::shift_width-1:0] shift;

	dsp_core u_core (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.command_reg_write(command_reg_write),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_reg_write_val(command_reg_write_val),
		.instr(instr),
		.reg_fetch(reg_fetch),
		.ch_fetch(ch_fetch),
		.last_block(last_block),
		.alu_result(alu_result),
		.clamp_max(clamp_max),
		.clamp_min(clamp_min),
		.sample_out(sample_out),
		.ready(ready),
		.reg_write_ack(reg_write_ack),
		.sample_load(sample_load),
		.current_block(current_block),
		.reg_fetch_addr(reg_fetch_addr),
		.ch_fetch_addr(ch_fetch_addr),
		.reg_write(reg_write),
		.reg_write_addr(reg_write_addr),
		.reg_write_val(reg_write_val),
		.ch_write(ch_write),
		.ch_write_addr(ch_write_addr),
		.ch_write_val(ch_write_val),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.opnd_c(opnd_c),
		.alu_op(alu_op),
		.saturate(saturate),
		.shift(shift)
	);

	block_store u_store (
		.clk(clk),
		.reset(reset),
		.command_instr_write(command_instr_write),
		.command_block_target(command_block_target),
		.command_instr_write_val(command_instr_write_val),
		.current_block(current_block),
		.reg_write(reg_write),
		.reg_write_addr(reg_write_addr),
		.reg_write_val(reg_write_val),
		.reg_fetch_addr(reg_fetch_addr),
		.ch_write(ch_write),
		.ch_write_addr(ch_write_addr),
		.ch_write_val(ch_write_val),
		.ch_fetch_addr(ch_fetch_addr),
		.sample_load(sample_load),
		.sample_in(sample_in),
		.instr(instr),
		.reg_fetch(reg_fetch),
		.ch_fetch(ch_fetch),
		.last_block(last_block)
	);

	dsp_alu u_alu (
		.alu_op(alu_op),
		.opnd_a(opnd_a),
		.opnd_b(opnd_b),
		.opnd_c(opnd_c),
		.saturate(saturate),
		.shift(shift),
		.alu_result(alu_result),
		.clamp_max(clamp_max),
		.clamp_min(clamp_min)
	);

endmodule

//--- sim.f
hw/dsp_pkg.sv
hw/dsp_alu.sv
hw/block_store.sv
hw/dsp_core.sv
hw/dsp_top.sv
tests/dsp_top_chk.sv
tests/dsp_top_tb.sv

//--- tests/dsp_top_chk.sv
module dsp_top_chk (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic ready,
	input logic reg_write_ack,
	input logic signed [dsp_pkg::data_width-1:0] sample_out
);
	timeunit 1ns;
	timeprecision 1ps;

	// Read by the testbench after each result
	int unsigned error_count = 0;

	// Core comes out of reset idle
	reset_idle: assert property (@(posedge clk) reset |=> ready)
		else begin
			error_count++;
			$error("ready low in the cycle after reset");
		end

	tick_starts_chain: assert property (@(posedge clk) disable iff (reset)
		(ready && tick) |=> !ready)
		else begin
			error_count++;
			$error("ready did not fall after a tick");
		end

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		reg_write_ack |=> !reg_write_ack)
		else begin
			error_count++;
			$error("reg_write_ack held for two cycles");
		end

	ack_only_idle: assert property (@(posedge clk) disable iff (reset)
		reg_write_ack |-> ready)
		else begin
			error_count++;
			$error("reg_write_ack while the chain is running");
		end

	// Output only moves on the edge where ready rises
	output_stable: assert property (@(posedge clk) disable iff (reset)
		ready |=> (!ready || $stable(sample_out)))
		else begin
			error_count++;
			$error("sample_out changed while ready stayed high");
		end

endmodule

bind dsp_top dsp_top_chk chk (
	.clk(clk),
	.reset(reset),
	.tick(tick),
	.ready(ready),
	.reg_write_ack(reg_write_ack),
	.sample_out(sample_out)
);

//--- tests/dsp_top_tb.sv
module dsp_top_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef logic signed [dsp_pkg::data_width-1:0] sample_t;
	typedef logic [dsp_pkg::instr_width-1:0] instr_t;

	// About 120 ticks, each at most 16 blocks of 12 cycles plus 4
	localparam int timeout_cycles = 30000;

	logic clk;
	logic reset;
	logic tick;
	sample_t sample_in;
	sample_t sample_out;
	logic ready;
	logic command_reg_write;
	logic command_instr_write;
	logic [dsp_pkg::block_addr_width-1:0] command_block_target;
	logic [dsp_pkg::reg_addr_width-1:0] command_reg_target;
	instr_t command_instr_write_val;
	sample_t command_reg_write_val;
	logic reg_write_ack;

	// Reference model state
	instr_t model_instr [dsp_pkg::n_blocks];
	sample_t model_regs [dsp_pkg::n_blocks * dsp_pkg::n_registers];
	sample_t model_ch [dsp_pkg::n_channels];
	int model_last;
	int cycle_count;

	dsp_top UUT (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.sample_in(sample_in),
		.sample_out(sample_out),
		.ready(ready),
		.command_reg_write(command_reg_write),
		.command_instr_write(command_instr_write),
		.command_block_target(command_block_target),
		.command_reg_target(command_reg_target),
		.command_instr_write_val(command_instr_write_val),
		.command_reg_write_val(command_reg_write_val),
		.reg_write_ack(reg_write_ack)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Run hung: no end after %0d cycles", cycle_count);
			stop_on_failure();
		end
	end

	task automatic stop_on_failure();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string msg);
		$display("error %0t: %s", $time, msg);
		stop_on_failure();
	endtask

	function automatic instr_t encode(
		input dsp_pkg::opcode_t op,
		input logic [3:0] a,
		input logic [3:0] b,
		input logic [3:0] c,
		input logic [3:0] dest,
		input logic [3:0] kinds,
		input logic nosat,
		input logic [2:0] sh
	);
		return {sh, nosat, kinds, dest, c, b, a, op};
	endfunction

	function automatic sample_t clip(input longint value, input logic sat);
		sample_t result;
		if (sat && value > 32767) begin
			result = 16'sh7fff;
		end else if (sat && value < -32768) begin
			result = 16'sh8000;
		end else begin
			result = sample_t'(value);
		end
		return result;
	endfunction

	function automatic sample_t read_operand(input int blk, input logic [3:0] addr,
		input logic is_reg);
		sample_t value;
		if (is_reg) begin
			value = model_regs[blk * dsp_pkg::n_registers + addr];
		end else begin
			value = model_ch[addr];
		end
		return value;
	endfunction

	task automatic run_block(input int blk);
		instr_t w;
		sample_t oa;
		sample_t ob;
		sample_t oc;
		sample_t product;
		sample_t value;
		logic sat;
		int sh;
		longint wide;
		longint hi;
		longint lo;
		w = model_instr[blk];
		oa = read_operand(blk, w[dsp_pkg::src_a_lsb +: 4], w[dsp_pkg::type_lsb]);
		ob = read_operand(blk, w[dsp_pkg::src_b_lsb +: 4], w[dsp_pkg::type_lsb + 1]);
		oc = read_operand(blk, w[dsp_pkg::src_c_lsb +: 4], w[dsp_pkg::type_lsb + 2]);
		sat = !w[dsp_pkg::nosat_bit];
		sh = w[dsp_pkg::shift_lsb +: 3];
		// Q1.15 product, extra shift moves it left
		wide = (longint'(oa) * longint'(ob)) >>> (15 - sh);
		product = clip(wide, sat);
		hi = 32767 >>> sh;
		lo = -32768 >>> sh;
		case (w[3:0])
			dsp_pkg::op_add: value = clip(longint'(oa) + longint'(ob), sat);
			dsp_pkg::op_sub: value = clip(longint'(oa) - longint'(ob), sat);
			dsp_pkg::op_mul: value = product;
			dsp_pkg::op_mac: value = clip(longint'(product) + longint'(oc), sat);
			dsp_pkg::op_lsh: value = oa << 1;
			dsp_pkg::op_rsh: value = $unsigned(oa) >> 1;
			dsp_pkg::op_arsh: value = oa >>> 1;
			dsp_pkg::op_abs: value = (oa < 0) ? -oa : oa;
			dsp_pkg::op_mov: value = oa;
			dsp_pkg::op_clamp: begin
				if (oa > hi) begin
					value = sample_t'(hi);
				end else if (oa < lo) begin
					value = sample_t'(lo);
				end else begin
					value = oa;
				end
			end
			dsp_pkg::op_gw: begin
				model_regs[oa[7:0]] = ob;
				return;
			end
			default: return;
		endcase
		if (w[dsp_pkg::type_lsb + 3]) begin
			model_regs[blk * dsp_pkg::n_registers + w[dsp_pkg::dest_lsb +: 4]] = value;
		end else begin
			model_ch[w[dsp_pkg::dest_lsb +: 4]] = value;
		end
	endtask

	task automatic predict_tick(input sample_t s, output sample_t expected);
		model_ch[0] = s;
		for (int blk = 0; blk <= model_last; blk++) begin
			run_block(blk);
		end
		expected = model_ch[0];
	endtask

	task automatic load_instr(input int blk, input instr_t w);
		@(negedge clk);
		command_block_target = blk[3:0];
		command_instr_write_val = w;
		command_instr_write = 1'b1;
		@(negedge clk);
		command_instr_write = 1'b0;
		model_instr[blk] = w;
		if (blk > model_last) begin
			model_last = blk;
		end
	endtask

	// Chain length never shrinks, so unused blocks go back to nop
	task automatic clear_program();
		for (int blk = 0; blk <= model_last; blk++) begin
			load_instr(blk, '0);
		end
	endtask

	task automatic write_register(input logic [3:0] blk, input logic [3:0] r,
		input sample_t val);
		int acks;
		acks = 0;
		@(negedge clk);
		command_block_target = blk;
		command_reg_target = r;
		command_reg_write_val = val;
		command_reg_write = 1'b1;
		repeat (5) begin
			@(negedge clk);
			if (reg_write_ack) begin
				acks++;
			end
		end
		command_reg_write = 1'b0;
		assert (acks == 1)
			else report_mismatch($sformatf("%0d reg_write_ack pulses, expected 1", acks));
		model_regs[{blk, r}] = val;
	endtask

	task automatic run_tick(input sample_t s);
		sample_t expected;
		@(negedge clk);
		sample_in = s;
		tick = 1'b1;
		@(negedge clk);
		tick = 1'b0;
		while (!ready) begin
			@(negedge clk);
		end
		predict_tick(s, expected);
		assert (sample_out === expected)
			else report_mismatch($sformatf("sample_out %0d, expected %0d for sample_in %0d",
				sample_out, expected, s));
		if (UUT.chk.error_count != 0) begin
			$display("Protocol assertion failed on the tick with sample_in %0d", s);
			stop_on_failure();
		end
	endtask

	// Extreme samples first, then random ones
	task automatic run_batch(input int n);
		sample_t s;
		for (int i = 0; i < n + 4; i++) begin
			case (i)
				0: s = 16'sh7fff;
				1: s = 16'sh8000;
				2: s = -16'sd1;
				3: s = 16'sd0;
				default: s = sample_t'($urandom);
			endcase
			run_tick(s);
		end
	endtask

	initial begin
		instr_t w;
		void'($urandom(32'hf705ea04));
		reset = 1'b1;
		tick = 1'b0;
		sample_in = '0;
		command_reg_write = 1'b0;
		command_instr_write = 1'b0;
		command_block_target = '0;
		command_reg_target = '0;
		command_instr_write_val = '0;
		command_reg_write_val = '0;
		cycle_count = 0;
		model_last = 0;
		foreach (model_instr[i]) model_instr[i] = '0;
		foreach (model_ch[i]) model_ch[i] = '0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		// Idle core passes the sample straight through
		assert (ready === 1'b1 && reg_write_ack === 1'b0)
			else report_mismatch("ready or reg_write_ack wrong after reset");
		run_batch(2);

		write_register(4'd0, 4'd3, 16'sh1234);
		load_instr(0, encode(dsp_pkg::op_mov, 4'd3, 4'd0, 4'd0, 4'd0, 4'b0001, 1'b0, 3'd0));
		run_tick(16'sd5);
		write_register(4'd0, 4'd3, -16'sd1000);
		run_tick(16'sd7);

		// Coefficients push the chain past both ends of the range
		for (int nosat = 0; nosat < 2; nosat++) begin
			clear_program();
			write_register(4'd0, 4'd1, 16'sh6000);
			write_register(4'd1, 4'd2, 16'sh7000);
			load_instr(0, encode(dsp_pkg::op_add, 4'd0, 4'd1, 4'd0, 4'd1, 4'b0010,
				nosat[0], 3'd0));
			load_instr(1, encode(dsp_pkg::op_sub, 4'd1, 4'd2, 4'd0, 4'd2, 4'b0010,
				nosat[0], 3'd0));
			load_instr(2, encode(dsp_pkg::op_add, 4'd2, 4'd0, 4'd0, 4'd0, 4'b0000,
				nosat[0], 3'd0));
			run_batch(10);
		end

		// Shift 0 and 2, each with and without saturation
		for (int cfg = 0; cfg < 4; cfg++) begin
			clear_program();
			write_register(4'd0, 4'd0, 16'sh4000);
			write_register(4'd1, 4'd0, 16'sh6000);
			load_instr(0, encode(dsp_pkg::op_mul, 4'd0, 4'd0, 4'd0, 4'd1, 4'b0010,
				cfg[0], cfg[1] ? 3'd2 : 3'd0));
			load_instr(1, encode(dsp_pkg::op_mac, 4'd0, 4'd0, 4'd1, 4'd0, 4'b0010,
				cfg[0], cfg[1] ? 3'd2 : 3'd0));
			run_batch(5);
		end

		for (int op = 0; op < 8; op++) begin
			clear_program();
			case (op)
				0: w = encode(dsp_pkg::op_lsh, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0, 3'd0);
				1: w = encode(dsp_pkg::op_rsh, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0, 3'd0);
				2: w = encode(dsp_pkg::op_arsh, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0, 3'd0);
				3: w = encode(dsp_pkg::op_abs, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0, 3'd0);
				default: w = encode(dsp_pkg::op_clamp, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0000, 1'b0,
					3'(2 * op - 7));
			endcase
			load_instr(0, w);
			run_batch(3);
		end

		// Block 1 rewrites the coefficient of block 0, low byte of 16'h7a00 is the address
		clear_program();
		write_register(4'd0, 4'd0, 16'sh2000);
		write_register(4'd1, 4'd0, 16'sh7a00);
		write_register(4'd1, 4'd1, -16'sh3000);
		load_instr(0, encode(dsp_pkg::op_mul, 4'd0, 4'd0, 4'd0, 4'd0, 4'b0010, 1'b0, 3'd0));
		load_instr(1, encode(dsp_pkg::op_gw, 4'd0, 4'd1, 4'd0, 4'd0, 4'b0011, 1'b0, 3'd0));
		run_batch(4);

		if (UUT.chk.error_count != 0) begin
			$display("Protocol assertion failed %0d times", UUT.chk.error_count);
			stop_on_failure();
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule
